//--- hdl/lbs_config.svh
`ifndef LBS_CONFIG_SVH
`define LBS_CONFIG_SVH

// Original camera frame.
`define LBS_ORIG_W 16
`define LBS_ORIG_H 16

// Decimation by two in each direction.
`define LBS_SCALE_SHIFT 1
`define LBS_RES_W (`LBS_ORIG_W >> `LBS_SCALE_SHIFT)

`define LBS_COORD_W 5

// Cascade depth.
`define LBS_NUM_STAGES 4
`define LBS_STAGE_W 2

`endif

//--- hdl/lbs_pkg.sv
`include "lbs_config.svh"

// LBP code of a window, bit set when neighbour >= centre:
//   bit 0 top-left, bit 1 top, bit 2 top-right, bit 3 right,
//   bit 4 bottom-right, bit 5 bottom, bit 6 bottom-left, bit 7 left.
// A stage passes when code and key agree on every bit set in mask.
package lbs_pkg;

	typedef logic [7:0] pixel_t;

	typedef logic [`LBS_COORD_W-1:0] coord_t;

	// Raster order, 0 top-left, 4 centre, 8 bottom-right.
	typedef pixel_t [8:0] window_t;

	typedef struct packed
	{
		logic [7:0] key;   // Expected code bits.
		logic [7:0] mask;  // Bits tested by the stage.
	} db_entry_t;

	typedef enum logic [1:0]
	{
		ST_RECEIVE,
		ST_WRITE,
		ST_INSPECT
	} ctrl_state_t;

	typedef enum logic [1:0]
	{
		EV_IDLE,
		EV_REQ,
		EV_WAIT_ACK_LOW,
		EV_DONE
	} eval_state_t;

endpackage

//--- hdl/lbs_window_if.sv
`timescale 1ns/10ps

// Completed 3x3 window with its bottom-right resized position.
interface lbs_window_if;

	lbs_pkg::window_t win;
	logic             valid;  // Last write completed a window.
	lbs_pkg::coord_t  win_x;
	lbs_pkg::coord_t  win_y;

	modport buf_mp
	(
		output win,
		output valid,
		output win_x,
		output win_y
	);

	modport eval_mp
	(
		input win,
		input valid,
		input win_x,
		input win_y
	);

endinterface

//--- hdl/lbs_window_buffer.sv
`timescale 1ns/10ps
`include "lbs_config.svh"

module lbs_window_buffer
(
	input  logic            clk_fpga,
	input  logic            reset_fpga,
	input  logic            i_write_en,
	input  lbs_pkg::pixel_t i_pixel,
	input  lbs_pkg::coord_t i_ori_x,
	input  lbs_pkg::coord_t i_ori_y,
	lbs_window_if.buf_mp    win_buf
);

	localparam int COL_W = $clog2(`LBS_RES_W);

	lbs_pkg::pixel_t  line_store [3][`LBS_RES_W];  // Three resized rows, circular.
	lbs_pkg::coord_t  res_x;
	lbs_pkg::coord_t  res_y;
	logic             keep;
	logic [1:0]       wr_row;
	logic [1:0]       row_sel [3];
	logic [COL_W-1:0] col_base;

	// ----------------------------------------
	// Decimation
	// ----------------------------------------

	assign keep  = (i_ori_x[`LBS_SCALE_SHIFT-1:0] == '0) &&
	               (i_ori_y[`LBS_SCALE_SHIFT-1:0] == '0);
	assign res_x = i_ori_x >> `LBS_SCALE_SHIFT;
	assign res_y = i_ori_y >> `LBS_SCALE_SHIFT;
	assign wr_row = 2'(res_y % 3);  // Row slot for this resized line.

	// ----------------------------------------
	// Line store and window position
	// ----------------------------------------

	always_ff @(posedge clk_fpga)
	begin
		if (reset_fpga)
			win_buf.valid <= 1'b0;
		else if (i_write_en)
			win_buf.valid <= keep && (res_x >= 2) && (res_y >= 2);  // Odd pixels clear it.
	end

	always_ff @(posedge clk_fpga)
	begin
		if (i_write_en && keep)
		begin
			line_store[wr_row][res_x[COL_W-1:0]] <= i_pixel;
			win_buf.win_x <= res_x;
			win_buf.win_y <= res_y;
			// Slots of rows y-2, y-1 and y.
			row_sel[0] <= 2'((res_y + 1) % 3);
			row_sel[1] <= 2'((res_y + 2) % 3);
			row_sel[2] <= wr_row;
			col_base <= COL_W'(res_x - 2);
		end
	end

	// Window assembly, raster order.
	always_comb
	begin
		for (int r = 0; r < 3; r++)
		begin
			for (int c = 0; c < 3; c++)
			begin
				win_buf.win[r * 3 + c] = line_store[row_sel[r]][col_base + COL_W'(c)];
			end
		end
	end

	// ----------------------------------------
	// Checks
	// ----------------------------------------

	// Coordinates from the camera side stay inside the original frame.
	a_coord_range: assert property (
		@(posedge clk_fpga) disable iff (reset_fpga)
		i_write_en |-> (i_ori_x < `LBS_ORIG_W) && (i_ori_y < `LBS_ORIG_H)
	);

endmodule

//--- hdl/lbs_stage_eval.sv
`timescale 1ns/10ps
`include "lbs_config.svh"

module lbs_stage_eval
(
	input  logic                    clk_fpga,
	input  logic                    reset_fpga,
	input  logic                    i_start,
	input  logic                    i_db_ack,
	input  lbs_pkg::db_entry_t      i_db_data,
	lbs_window_if.eval_mp           win_eval,
	output logic                    o_db_req,
	output logic [`LBS_STAGE_W-1:0] o_db_stage,
	output logic                    o_done,
	output logic                    o_candidate
);

	// Window index of the neighbour behind each LBP bit.
	localparam int NB_IDX [8] = '{0, 1, 2, 5, 8, 7, 6, 3};

	lbs_pkg::eval_state_t state;
	logic [7:0]           lbp_now;
	logic [7:0]           lbp_code;
	logic                 stage_pass;
	logic                 last_stage;
	logic                 finish;  // Verdict known, stop after ack drops.

	always_comb
	begin
		for (int b = 0; b < 8; b++)
			lbp_now[b] = (win_eval.win[NB_IDX[b]] >= win_eval.win[4]);
	end

	assign stage_pass = ((lbp_code ^ i_db_data.key) & i_db_data.mask) == 8'h00;
	assign last_stage = (o_db_stage == `LBS_STAGE_W'(`LBS_NUM_STAGES - 1));
	assign o_db_req   = (state == lbs_pkg::EV_REQ);
	assign o_done     = (state == lbs_pkg::EV_DONE);

	always_ff @(posedge clk_fpga)
	begin
		if ((state == lbs_pkg::EV_IDLE) && i_start)
			lbp_code <= lbp_now;
	end

	// ----------------------------------------
	// Cascade with four-phase fetch
	// ----------------------------------------

	always_ff @(posedge clk_fpga)
	begin
		if (reset_fpga)
		begin
			state       <= lbs_pkg::EV_IDLE;
			o_db_stage  <= '0;
			finish      <= 1'b0;
			o_candidate <= 1'b0;
		end
		else
		begin
			case (state)
				lbs_pkg::EV_IDLE:
				begin
					if (i_start)
					begin
						state      <= lbs_pkg::EV_REQ;
						o_db_stage <= '0;
						finish     <= 1'b0;
					end
				end
				lbs_pkg::EV_REQ:
				begin
					if (i_db_ack)
					begin
						state <= lbs_pkg::EV_WAIT_ACK_LOW;
						if (!stage_pass || last_stage)
						begin
							finish      <= 1'b1;
							o_candidate <= stage_pass;  // Last stage passed.
						end
					end
				end
				lbs_pkg::EV_WAIT_ACK_LOW:
				begin
					if (!i_db_ack)
					begin
						if (finish)
							state <= lbs_pkg::EV_DONE;
						else
						begin
							state      <= lbs_pkg::EV_REQ;
							o_db_stage <= o_db_stage + 1'b1;
						end
					end
				end
				default:
					state <= lbs_pkg::EV_IDLE;
			endcase
		end
	end

	// Ack answers a pending request.
	a_ack_after_req: assert property (
		@(posedge clk_fpga) disable iff (reset_fpga)
		$rose(i_db_ack) |-> o_db_req
	);

	// Control never restarts an inspection in flight.
	a_start_idle: assert property (
		@(posedge clk_fpga) disable iff (reset_fpga)
		i_start |-> (state == lbs_pkg::EV_IDLE)
	);

endmodule

//--- hdl/lbs_control.sv
`timescale 1ns/10ps

module lbs_control
(
	input  logic            clk_fpga,
	input  logic            reset_fpga,
	input  logic            i_pixel_recv,
	input  logic            i_eval_done,
	input  logic            i_eval_candidate,
	lbs_window_if.eval_mp   win_ctl,
	output logic            o_pixel_req,
	output logic            o_write_en,
	output logic            o_eval_start,
	output logic            o_inspect_done,
	output logic            o_candidate,
	output lbs_pkg::coord_t o_win_x,
	output lbs_pkg::coord_t o_win_y
);

	lbs_pkg::ctrl_state_t state;
	lbs_pkg::ctrl_state_t next_state;

	assign o_pixel_req  = (state == lbs_pkg::ST_RECEIVE);
	assign o_write_en   = o_pixel_req && i_pixel_recv;  // Accepted pixel.
	assign o_eval_start = (state == lbs_pkg::ST_WRITE) && win_ctl.valid;

	always_comb
	begin
		next_state = state;
		case (state)
			lbs_pkg::ST_RECEIVE:
				if (i_pixel_recv)
					next_state = lbs_pkg::ST_WRITE;
			lbs_pkg::ST_WRITE:
				next_state = win_ctl.valid ? lbs_pkg::ST_INSPECT : lbs_pkg::ST_RECEIVE;
			lbs_pkg::ST_INSPECT:
				if (o_inspect_done)
					next_state = lbs_pkg::ST_RECEIVE;
			default:
				next_state = lbs_pkg::ST_RECEIVE;
		endcase
	end

	always_ff @(posedge clk_fpga)
	begin
		if (reset_fpga)
		begin
			state          <= lbs_pkg::ST_RECEIVE;
			o_inspect_done <= 1'b0;
			o_candidate    <= 1'b0;
		end
		else
		begin
			state          <= next_state;
			o_inspect_done <= (state == lbs_pkg::ST_INSPECT) && i_eval_done;
			if (i_eval_done)
				o_candidate <= i_eval_candidate;
		end
	end

	// Position held by the buffer, no writes during inspection.
	always_ff @(posedge clk_fpga)
	begin
		if (i_eval_done)
		begin
			o_win_x <= win_ctl.win_x;
			o_win_y <= win_ctl.win_y;
		end
	end

	// Evaluator results arrive only while inspecting.
	a_done_in_inspect: assert property (
		@(posedge clk_fpga) disable iff (reset_fpga)
		i_eval_done |-> (state == lbs_pkg::ST_INSPECT)
	);

endmodule

//--- hdl/lbs_detector_top.sv
`timescale 1ns/10ps
`include "lbs_config.svh"

module lbs_detector_top
(
	input  logic                    clk_fpga,
	input  logic                    reset_fpga,
	input  logic [7:0]              i_pixel,
	input  logic [`LBS_COORD_W-1:0] i_ori_x,
	input  logic [`LBS_COORD_W-1:0] i_ori_y,
	input  logic                    i_pixel_recv,
	input  logic                    i_db_ack,
	input  logic [15:0]             i_db_data,
	output logic                    o_pixel_req,
	output logic                    o_db_req,
	output logic [`LBS_STAGE_W-1:0] o_db_stage,
	output logic                    o_inspect_done,
	output logic                    o_candidate,
	output logic [`LBS_COORD_W-1:0] o_win_x,
	output logic [`LBS_COORD_W-1:0] o_win_y
);

	logic write_en;
	logic eval_start;
	logic eval_done;
	logic eval_candidate;

	lbs_window_if win_if ();

	lbs_control u_control
	(
		.clk_fpga         (clk_fpga),
		.reset_fpga       (reset_fpga),
		.i_pixel_recv     (i_pixel_recv),
		.i_eval_done      (eval_done),
		.i_eval_candidate (eval_candidate),
		.win_ctl          (win_if.eval_mp),
		.o_pixel_req      (o_pixel_req),
		.o_write_en       (write_en),
		.o_eval_start     (eval_start),
		.o_inspect_done   (o_inspect_done),
		.o_candidate      (o_candidate),
		.o_win_x          (o_win_x),
		.o_win_y          (o_win_y)
	);

	lbs_window_buffer u_window_buffer
	(
		.clk_fpga   (clk_fpga),
		.reset_fpga (reset_fpga),
		.i_write_en (write_en),
		.i_pixel    (i_pixel),
		.i_ori_x    (i_ori_x),
		.i_ori_y    (i_ori_y),
		.win_buf    (win_if.buf_mp)
	);

	lbs_stage_eval u_stage_eval
	(
		.clk_fpga    (clk_fpga),
		.reset_fpga  (reset_fpga),
		.i_start     (eval_start),
		.i_db_ack    (i_db_ack),
		.i_db_data   (i_db_data),
		.win_eval    (win_if.eval_mp),
		.o_db_req    (o_db_req),
		.o_db_stage  (o_db_stage),
		.o_done      (eval_done),
		.o_candidate (eval_candidate)
	);

endmodule

//--- verification/tb_lbs_detector.sv
`timescale 1ns/10ps
`include "lbs_config.svh"

module tb_lbs_detector;

	localparam int WAIT_LIMIT = 50;
	localparam int RES_H      = `LBS_ORIG_H >> `LBS_SCALE_SHIFT;
	localparam int SCALE      = 1 << `LBS_SCALE_SHIFT;

	logic                    clk_fpga;
	logic                    reset_fpga;
	logic [7:0]              i_pixel;
	logic [`LBS_COORD_W-1:0] i_ori_x;
	logic [`LBS_COORD_W-1:0] i_ori_y;
	logic                    i_pixel_recv;
	logic                    i_db_ack;
	logic [15:0]             i_db_data;
	logic                    o_pixel_req;
	logic                    o_db_req;
	logic [`LBS_STAGE_W-1:0] o_db_stage;
	logic                    o_inspect_done;
	logic                    o_candidate;
	logic [`LBS_COORD_W-1:0] o_win_x;
	logic [`LBS_COORD_W-1:0] o_win_y;

	integer             seed;
	int                 done_count = 0;
	lbs_pkg::db_entry_t db_table [`LBS_NUM_STAGES];
	lbs_pkg::pixel_t    res_img [RES_H][`LBS_RES_W];  // Model's resized frame.

	lbs_detector_top dut0
	(
		.clk_fpga       (clk_fpga),
		.reset_fpga     (reset_fpga),
		.i_pixel        (i_pixel),
		.i_ori_x        (i_ori_x),
		.i_ori_y        (i_ori_y),
		.i_pixel_recv   (i_pixel_recv),
		.i_db_ack       (i_db_ack),
		.i_db_data      (i_db_data),
		.o_pixel_req    (o_pixel_req),
		.o_db_req       (o_db_req),
		.o_db_stage     (o_db_stage),
		.o_inspect_done (o_inspect_done),
		.o_candidate    (o_candidate),
		.o_win_x        (o_win_x),
		.o_win_y        (o_win_y)
	);

	initial
	begin
		clk_fpga = 1'b0;
		forever #2 clk_fpga = ~clk_fpga;
	end

	// Counts every result pulse, wanted or not.
	always @(negedge clk_fpga)
	begin
		if (!reset_fpga && o_inspect_done)
			done_count++;
	end

	// ----------------------------------------
	// Reporting
	// ----------------------------------------

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("SIMULATION FAILED");
		$fatal(1, "Stopped at first error.");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
			report_failure($sformatf("Mismatch at time %0t: %s expected %0h, got %0h",
				$time, name, expected, actual));
	endtask

	task automatic next_cycle();
		@(posedge clk_fpga);
		#1;
	endtask

	// No pixel may be requested while a window is inspected.
	task automatic inspect_cycle();
		next_cycle();
		check_value("o_pixel_req", 32'd0, 32'(o_pixel_req));
	endtask

	// ----------------------------------------
	// Model
	// ----------------------------------------

	// Window rows y-2..y and columns x-2..x, centre at (x-1, y-1).
	function automatic logic [7:0] lbp_code_of(input int x, input int y);
		int         nx [8];
		int         ny [8];
		logic [7:0] code;
		nx = '{x - 2, x - 1, x, x, x, x - 1, x - 2, x - 2};
		ny = '{y - 2, y - 2, y - 2, y - 1, y, y, y, y - 1};
		for (int b = 0; b < 8; b++)
			code[b] = (res_img[ny[b]][nx[b]] >= res_img[y - 1][x - 1]);
		return code;
	endfunction

	task automatic predict_cascade(input logic [7:0] code, output int fetches,
		output logic cand);
		fetches = `LBS_NUM_STAGES;
		cand    = 1'b1;
		for (int s = 0; s < `LBS_NUM_STAGES; s++)
		begin
			if (cand && ((code & db_table[s].mask) != (db_table[s].key & db_table[s].mask)))
			begin
				fetches = s + 1;  // First failing stage ends the cascade.
				cand    = 1'b0;
			end
		end
	endtask

	// ----------------------------------------
	// Stimulus and database responder
	// ----------------------------------------

	task automatic send_pixel(input int x, input int y, output logic window);
		lbs_pkg::pixel_t value;
		int              n;
		value = 8'($random(seed));
		repeat ($random(seed) & 3)
		begin
			i_pixel_recv = 1'b0;
			i_pixel      = 8'($random(seed));
			next_cycle();
		end
		i_pixel      = value;
		i_ori_x      = `LBS_COORD_W'(x);
		i_ori_y      = `LBS_COORD_W'(y);
		i_pixel_recv = 1'b1;
		n = 0;
		while (!o_pixel_req)
		begin
			next_cycle();
			n++;
			if (n > WAIT_LIMIT)
				report_failure($sformatf("No pixel request for pixel (%0d, %0d)", x, y));
		end
		next_cycle();  // Taken on this edge.
		check_value("o_pixel_req", 32'd0, 32'(o_pixel_req));
		window = 1'b0;
		if ((x % SCALE == 0) && (y % SCALE == 0))
		begin
			res_img[y / SCALE][x / SCALE] = value;
			window = (x / SCALE >= 2) && (y / SCALE >= 2);
		end
		i_pixel      = 8'($random(seed));
		i_pixel_recv = window;  // Held high through an inspection.
	endtask

	task automatic run_inspection(input int x, input int y);
		logic [7:0] code;
		logic       cand;
		int         fetches;
		int         n;
		code = lbp_code_of(x, y);
		predict_cascade(code, fetches, cand);
		for (int s = 0; s < fetches; s++)
		begin
			n = 0;
			while (!o_db_req)
			begin
				inspect_cycle();
				n++;
				if (n > WAIT_LIMIT)
					report_failure($sformatf("No database request for stage %0d", s));
			end
			check_value("o_db_stage", 32'(s), 32'(o_db_stage));
			repeat ($random(seed) & 3)
			begin
				inspect_cycle();
				check_value("o_db_req", 32'd1, 32'(o_db_req));
			end
			i_db_ack  = 1'b1;
			i_db_data = db_table[s];
			inspect_cycle();
			check_value("o_db_req", 32'd0, 32'(o_db_req));
			repeat ($random(seed) & 1)
			begin
				inspect_cycle();
				check_value("o_db_req", 32'd0, 32'(o_db_req));  // Ack still high.
			end
			i_db_ack  = 1'b0;
			i_db_data = 16'($random(seed));
		end
		n = 0;
		while (!o_inspect_done)
		begin
			inspect_cycle();
			check_value("o_db_req", 32'd0, 32'(o_db_req));
			n++;
			if (n > WAIT_LIMIT)
				report_failure($sformatf("No result for window (%0d, %0d)", x, y));
		end
		check_value("o_candidate", 32'(cand), 32'(o_candidate));
		check_value("o_win_x", 32'(x), 32'(o_win_x));
		check_value("o_win_y", 32'(y), 32'(o_win_y));
	endtask

	initial
	begin
		logic window;
		int   frame_start;
		seed         = 32'h2c2a;
		reset_fpga   = 1'b1;
		i_pixel      = '0;
		i_ori_x      = '0;
		i_ori_y      = '0;
		i_pixel_recv = 1'b0;
		i_db_ack     = 1'b0;
		i_db_data    = '0;
		// Sparse masks so that some windows pass every stage.
		for (int s = 0; s < `LBS_NUM_STAGES; s++)
		begin
			db_table[s].key  = 8'($random(seed));
			db_table[s].mask = 8'($random(seed) & $random(seed) & $random(seed));
		end
		repeat (2) @(posedge clk_fpga);
		#1;
		reset_fpga = 1'b0;
		check_value("o_pixel_req", 32'd1, 32'(o_pixel_req));
		check_value("o_db_req", 32'd0, 32'(o_db_req));
		check_value("o_inspect_done", 32'd0, 32'(o_inspect_done));
		check_value("o_candidate", 32'd0, 32'(o_candidate));
		for (int f = 0; f < 2; f++)
		begin
			frame_start = done_count;
			for (int y = 0; y < `LBS_ORIG_H; y++)
			begin
				for (int x = 0; x < `LBS_ORIG_W; x++)
				begin
					send_pixel(x, y, window);
					if (window)
						run_inspection(x / SCALE, y / SCALE);
				end
			end
			next_cycle();
			check_value("results per frame", 32'((`LBS_RES_W - 2) * (RES_H - 2)),
				32'(done_count - frame_start));
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+hdl
hdl/lbs_pkg.sv
hdl/lbs_window_if.sv
hdl/lbs_window_buffer.sv
hdl/lbs_stage_eval.sv
hdl/lbs_control.sv
hdl/lbs_detector_top.sv
verification/tb_lbs_detector.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_lbs_detector
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
